// File: bench/keymap_tests.svh
/* directed keymap tests, reset state, prefixes, num lock,
   joystick lines, back-pressure and latency */
`ifndef KEYMAP_TESTS_SVH
`define KEYMAP_TESTS_SVH

   task automatic test_after_reset();
      test_name = "after_reset";
      @(negedge clk);
      check_flag("key_valid", 1'b0, key_valid);
      check_flag("scan_ready", 1'b1, scan_ready);
      check_numlock(1'b0, numlock);
      check_joy(6'h3f, joy);
      send_byte(SC_A);
      send_release(SC_A);
      expect_key(make_key(1'b0, AK_A));
      expect_key(make_key(1'b1, AK_A));
   endtask

   task automatic test_prefixes();
      test_name = "prefixes";
      send_ext(SC_RGUI, 1'b0);
      expect_key(make_key(1'b0, AK_RGUI));
      send_ext(SC_RGUI, 1'b1);
      expect_key(make_key(1'b1, AK_RGUI));
      send_byte(SC_REL);
      send_byte(SC_ACK); // ack inside a release sequence
      send_byte(SC_A);
      expect_key(make_key(1'b1, AK_A));
      send_byte(SC_ACK);
      send_byte(SC_EXT);
      send_byte(SC_REL);
      expect_no_key();
      send_byte(SC_RGUI); // finishes the pending E0 F0
      expect_key(make_key(1'b1, AK_RGUI));
   endtask

   task automatic test_numlock();
      test_name = "numlock";
      send_byte(SC_NUM);
      send_release(SC_NUM);
      expect_no_key();
      check_numlock(1'b1, numlock);
      send_byte(SC_KP8);
      send_ext(SC_LEFT, 1'b0);
      send_ext(SC_DOWN, 1'b0);
      send_byte(SC_CTRL);
      send_byte(SC_LALT);
      send_release(SC_KP8);
      send_ext(SC_LEFT, 1'b1);
      send_ext(SC_DOWN, 1'b1);
      send_release(SC_CTRL);
      send_release(SC_LALT);
      expect_no_key();
      send_byte(SC_A);
      expect_key(make_key(1'b0, AK_A));
      send_byte(SC_NUM);
      send_release(SC_NUM);
      expect_no_key();
      check_numlock(1'b0, numlock);
      send_byte(SC_KP8);
      expect_key(make_key(1'b0, AK_KP8));
   endtask

   task automatic test_joystick();
      test_name = "joystick";
      send_byte(SC_NUM);
      send_release(SC_NUM);
      send_ext(SC_LEFT, 1'b0);
      settle();
      check_joy(6'b111101, joy); // left low
      send_ext(SC_RIGHT, 1'b0);
      settle();
      check_joy(6'b111110, joy); // right low, left back high
      send_ext(SC_LEFT, 1'b1);
      send_ext(SC_RIGHT, 1'b1);
      settle();
      check_joy(6'h3f, joy);
      send_byte(SC_CTRL);
      settle();
      check_joy(6'b101111, joy); // fire 0
      send_byte(SC_LALT);
      settle();
      check_joy(6'b001111, joy); // both fires
      send_release(SC_CTRL);
      settle();
      check_joy(6'b011111, joy);
      send_release(SC_LALT);
      settle();
      check_joy(6'h3f, joy);
      send_ext(SC_UP, 1'b0);
      settle();
      check_joy(6'b110111, joy); // up held while num lock goes off
      send_byte(SC_NUM);
      send_release(SC_NUM);
      settle();
      check_numlock(1'b0, numlock);
      check_joy(6'h3f, joy);
      expect_no_key();
   endtask

   task automatic test_backpressure();
      amiga_code_t codes[8];
      codes = '{AK_A, AK_1, AK_SPACE, AK_KP8, AK_CTRL, AK_LALT, AK_UP, AK_RGUI};
      test_name = "backpressure";
      @(posedge clk);
      key_ready <= 1'b0;
      send_byte(SC_A);
      send_byte(SC_1);
      send_byte(SC_SPACE);
      send_byte(SC_KP8);
      send_byte(SC_CTRL); // stays in the stage
      settle();
      check_flag("scan_ready", 1'b0, scan_ready);
      fork
         begin
            send_byte(SC_LALT);
            send_ext(SC_UP, 1'b0);
            send_ext(SC_RGUI, 1'b0);
         end
         while (got_keys.size() < 8) begin
            @(posedge clk);
            rng_state = xorshift(rng_state);
            key_ready <= rng_state[0];
         end
      join
      @(posedge clk);
      key_ready <= 1'b1;
      foreach (codes[i])
         expect_key(make_key(1'b0, codes[i]));
      expect_no_key();
   endtask

   task automatic test_latency();
      test_name = "latency";
      send_byte(SC_SPACE);
      expect_key(make_key(1'b0, AK_SPACE));
      settle();
      send_byte(SC_REL);
      send_byte(SC_SPACE);
      @(negedge clk);
      check_flag("key_valid", 1'b0, key_valid);
      @(negedge clk);
      check_flag("key_valid", 1'b1, key_valid); // one cycle after acceptance
      expect_key(make_key(1'b1, AK_SPACE));
   endtask

`endif

// File: bench/keymap_tb.sv
/* testbench for the ps/2 to amiga keymap, clock, reset, DUT,
   key monitor, byte driver, compare tasks and run order */
`timescale 1ns/1ps
`default_nettype none

module keymap_tb import ps2_amiga_keymap_pkg::*; ();

   localparam int TIMEOUT_CYCLES = 3000;

   // scan codes and the amiga codes they map to
   localparam scan_byte_t  SC_EXT   = 8'he0;
   localparam scan_byte_t  SC_REL   = 8'hf0;
   localparam scan_byte_t  SC_ACK   = 8'hfa;
   localparam scan_byte_t  SC_A     = 8'h1c;
   localparam scan_byte_t  SC_1     = 8'h16;
   localparam scan_byte_t  SC_SPACE = 8'h29;
   localparam scan_byte_t  SC_CTRL  = 8'h14;
   localparam scan_byte_t  SC_LALT  = 8'h11;
   localparam scan_byte_t  SC_KP8   = 8'h75;
   localparam scan_byte_t  SC_NUM   = 8'h77;
   localparam scan_byte_t  SC_RGUI  = 8'h27; // E0 prefixed
   localparam scan_byte_t  SC_LEFT  = 8'h6b; // arrows are E0 prefixed
   localparam scan_byte_t  SC_RIGHT = 8'h74;
   localparam scan_byte_t  SC_DOWN  = 8'h72;
   localparam scan_byte_t  SC_UP    = 8'h75;
   localparam amiga_code_t AK_A     = 7'h20;
   localparam amiga_code_t AK_1     = 7'h01;
   localparam amiga_code_t AK_SPACE = 7'h40;
   localparam amiga_code_t AK_CTRL  = 7'h63;
   localparam amiga_code_t AK_LALT  = 7'h64;
   localparam amiga_code_t AK_KP8   = 7'h3e;
   localparam amiga_code_t AK_RGUI  = 7'h67;
   localparam amiga_code_t AK_UP    = 7'h4c;

   logic        clk = 1'b0;
   logic        reset;
   scan_byte_t  scan_code;
   logic        scan_valid;
   logic        scan_ready;
   amiga_key_t  key;
   logic        key_valid;
   logic        key_ready;
   logic        numlock;
   joy_t        joy;

   amiga_key_t  got_keys[$]; // popped keys, oldest first
   string       test_name;
   int          cycles = 0;
   logic [31:0] rng_state;

   ps2_amiga_keymap u_ps2_amiga_keymap (
      .clk        (clk),
      .reset      (reset),
      .scan_code  (scan_code),
      .scan_valid (scan_valid),
      .scan_ready (scan_ready),
      .key        (key),
      .key_valid  (key_valid),
      .key_ready  (key_ready),
      .numlock    (numlock),
      .joy        (joy)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == TIMEOUT_CYCLES)
         fail_run($sformatf("timeout, DUT made no progress within %0d cycles", TIMEOUT_CYCLES));
   end

   // record every key that pops on the next edge
   always @(negedge clk) begin
      if (!reset && key_valid && key_ready)
         got_keys.push_back(key);
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic amiga_key_t make_key(input logic upstroke, input amiga_code_t code);
      return {upstroke, code};
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Test failures found");
      $fatal(1, "stopped at first failure");
   endtask

   task automatic check_key(input amiga_key_t expected, input amiga_key_t actual);
      if (actual !== expected)
         fail_run($sformatf("error: %s key expected %h actual %h", test_name, expected, actual));
   endtask

   task automatic check_joy(input joy_t expected, input joy_t actual);
      if (actual !== expected)
         fail_run($sformatf("error: %s joy expected %b actual %b", test_name, expected, actual));
   endtask

   task automatic check_numlock(input logic expected, input logic actual);
      if (actual !== expected)
         fail_run($sformatf("error: %s numlock expected %b actual %b", test_name,
                            expected, actual));
   endtask

   task automatic check_flag(input string what, input logic expected, input logic actual);
      if (actual !== expected)
         fail_run($sformatf("error: %s %s expected %b actual %b", test_name, what,
                            expected, actual));
   endtask

   // returns on the edge that takes the byte
   task automatic send_byte(input scan_byte_t b);
      @(posedge clk);
      scan_code  <= b;
      scan_valid <= 1'b1;
      @(negedge clk);
      while (!scan_ready)
         @(negedge clk);
      @(posedge clk);
      scan_valid <= 1'b0;
   endtask

   task automatic send_release(input scan_byte_t b);
      send_byte(SC_REL);
      send_byte(b);
   endtask

   task automatic send_ext(input scan_byte_t b, input logic upstroke);
      send_byte(SC_EXT);
      if (upstroke)
         send_byte(SC_REL);
      send_byte(b);
   endtask

   task automatic settle();
      repeat (4) @(negedge clk); // long enough to drain the stage
   endtask

   task automatic expect_key(input amiga_key_t expected);
      amiga_key_t actual;
      while (got_keys.size() == 0)
         @(negedge clk);
      actual = got_keys.pop_front();
      check_key(expected, actual);
   endtask

   task automatic expect_no_key();
      settle();
      if (got_keys.size() != 0)
         fail_run($sformatf("%s: unexpected key %h came out of the DUT", test_name,
                            got_keys[0]));
   endtask

`include "keymap_tests.svh"

   initial begin
      reset      <= 1'b1;
      scan_code  <= '0;
      scan_valid <= 1'b0;
      key_ready  <= 1'b1;
      rng_state  = 32'd25240;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      test_after_reset();
      test_prefixes();
      test_numlock();
      test_joystick();
      test_backpressure();
      test_latency();
      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

// File: ps2_amiga_keymap.f
+incdir+bench
source/ps2_amiga_keymap_pkg.sv
source/scan_code_table.sv
source/scan_decode.sv
source/joystick_emu.sv
source/key_queue.sv
source/ps2_amiga_keymap.sv
bench/keymap_tb.sv

// File: run.sh
#!/bin/sh
# build the keymap testbench with verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module keymap_tb \
   -f ps2_amiga_keymap.f -o keymap_sim

./obj_dir/keymap_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// File: source/joystick_emu.sv
/* retires table entries, applies the num lock filter and keeps
   the num lock flag and the emulated joystick lines */
`timescale 1ns/1ps
`default_nettype none

module joystick_emu import ps2_amiga_keymap_pkg::*; (
   input  wire logic         clk,
   input  wire logic         reset,
   input  wire table_entry_t entry,
   input  wire logic         entry_upstroke,
   input  wire logic         entry_valid,
   input  wire logic         queue_ready,
   output logic              entry_take,
   output amiga_key_t        key_in,
   output logic              key_push,
   output logic              numlock,
   output joy_t              joy
);

   amiga_code_t code;
   logic        is_key;
   logic        is_arrow;
   logic        is_ctrl;
   logic        is_lalt;
   logic        blocked;

   assign code   = entry[CODE_W-1:0];
   assign is_key = entry[ENTRY_KEY];

   assign is_arrow = is_key && (code == JOY_KEY_UP || code == JOY_KEY_DOWN ||
                                code == JOY_KEY_LEFT || code == JOY_KEY_RIGHT);
   assign is_ctrl  = is_key && entry[ENTRY_CTRL];
   assign is_lalt  = is_key && entry[ENTRY_LALT];

   // keys owned by the joystick or keypad while num lock is on
   assign blocked = numlock && (entry[ENTRY_KEYPAD] || is_arrow || is_ctrl || is_lalt);

   assign entry_take = entry_valid && queue_ready;
   assign key_push   = entry_take && is_key && !blocked;
   assign key_in     = {entry_upstroke, code};

   always_ff @(posedge clk) begin
      if (reset)
         numlock <= 1'b0;
      else if (entry_take && entry[ENTRY_NUMLOCK] && !entry_upstroke)
         numlock <= !numlock; // toggle on press only
   end

   always_ff @(posedge clk) begin
      if (reset || !numlock) begin
         joy <= '1;
      end else if (entry_take && is_key) begin
         case (code)
            JOY_KEY_LEFT: begin
               joy[JOY_LEFT] <= entry_upstroke;
               if (!entry_upstroke)
                  joy[JOY_RIGHT] <= 1'b1; // opposite side released
            end
            JOY_KEY_RIGHT: begin
               joy[JOY_RIGHT] <= entry_upstroke;
               if (!entry_upstroke)
                  joy[JOY_LEFT] <= 1'b1;
            end
            JOY_KEY_UP: begin
               joy[JOY_UP] <= entry_upstroke;
               if (!entry_upstroke)
                  joy[JOY_DOWN] <= 1'b1;
            end
            JOY_KEY_DOWN: begin
               joy[JOY_DOWN] <= entry_upstroke;
               if (!entry_upstroke)
                  joy[JOY_UP] <= 1'b1;
            end
            default: ;
         endcase
         if (is_ctrl)
            joy[JOY_FIRE0] <= entry_upstroke;
         if (is_lalt)
            joy[JOY_FIRE1] <= entry_upstroke;
      end
   end

endmodule

`default_nettype wire

// File: source/key_queue.sv
/* small fifo of amiga key codes with valid/ready output */
`timescale 1ns/1ps
`default_nettype none

module key_queue import ps2_amiga_keymap_pkg::*; (
   input  wire logic       clk,
   input  wire logic       reset,
   input  wire amiga_key_t key_in,
   input  wire logic       key_push,
   output logic            queue_ready,
   output amiga_key_t      key,
   output logic            key_valid,
   input  wire logic       key_ready
);

   amiga_key_t             mem [KEY_QUEUE_DEPTH];
   logic [KEY_PTR_W-1:0]   wr_ptr;
   logic [KEY_PTR_W-1:0]   rd_ptr;
   logic [KEY_COUNT_W-1:0] count;
   logic                   do_push;
   logic                   do_pop;

   assign queue_ready = count != KEY_COUNT_W'(KEY_QUEUE_DEPTH);
   assign key_valid   = count != '0;
   assign key         = mem[rd_ptr]; // oldest entry

   assign do_push = key_push && queue_ready;
   assign do_pop  = key_valid && key_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= (wr_ptr == KEY_PTR_W'(KEY_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == KEY_PTR_W'(KEY_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (do_push)
         mem[wr_ptr] <= key_in;
   end

endmodule

`default_nettype wire

// File: source/ps2_amiga_keymap.sv
/* ps/2 set 2 to amiga keymap top, decode stage, joystick
   emulation and key queue */
`timescale 1ns/1ps
`default_nettype none

module ps2_amiga_keymap import ps2_amiga_keymap_pkg::*; (
   input  wire logic       clk,
   input  wire logic       reset,
   input  wire scan_byte_t scan_code,
   input  wire logic       scan_valid,
   output logic            scan_ready,
   output amiga_key_t      key,
   output logic            key_valid,
   input  wire logic       key_ready,
   output logic            numlock,
   output joy_t            joy
);

   table_entry_t entry;
   logic         entry_upstroke;
   logic         entry_valid;
   logic         entry_take;
   amiga_key_t   key_in;
   logic         key_push;
   logic         queue_ready;

   scan_decode u_scan_decode (
      .clk            (clk),
      .reset          (reset),
      .scan_code      (scan_code),
      .scan_valid     (scan_valid),
      .scan_ready     (scan_ready),
      .entry          (entry),
      .entry_upstroke (entry_upstroke),
      .entry_valid    (entry_valid),
      .entry_take     (entry_take)
   );

   joystick_emu u_joystick_emu (
      .clk            (clk),
      .reset          (reset),
      .entry          (entry),
      .entry_upstroke (entry_upstroke),
      .entry_valid    (entry_valid),
      .queue_ready    (queue_ready),
      .entry_take     (entry_take),
      .key_in         (key_in),
      .key_push       (key_push),
      .numlock        (numlock),
      .joy            (joy)
   );

   key_queue u_key_queue (
      .clk         (clk),
      .reset       (reset),
      .key_in      (key_in),
      .key_push    (key_push),
      .queue_ready (queue_ready),
      .key         (key),
      .key_valid   (key_valid),
      .key_ready   (key_ready)
   );

endmodule

`default_nettype wire

// File: source/ps2_amiga_keymap_pkg.sv
/* shared widths, table entry bit positions, joystick key codes,
   key queue sizing and the prefix tracker enum */
`default_nettype none

package ps2_amiga_keymap_pkg;

   localparam int SCAN_W  = 8;
   localparam int INDEX_W = SCAN_W + 1;
   localparam int ENTRY_W = 16;
   localparam int CODE_W  = 7;
   localparam int JOY_W   = 6;

   typedef logic [SCAN_W-1:0]  scan_byte_t;   // one ps/2 byte
   typedef logic [INDEX_W-1:0] table_index_t; // {extended, byte}
   typedef logic [ENTRY_W-1:0] table_entry_t;
   typedef logic [CODE_W-1:0]  amiga_code_t;
   typedef logic [CODE_W:0]    amiga_key_t;   // {release, code}
   typedef logic [JOY_W-1:0]   joy_t;         // active low

   // table entry bit positions
   localparam int ENTRY_KEY     = 15;
   localparam int ENTRY_CTRL    = 14;
   localparam int ENTRY_LALT    = 13;
   localparam int ENTRY_NUMLOCK = 10;
   localparam int ENTRY_KEYPAD  = 9;
   localparam int ENTRY_PREFIX  = 7;

   // protocol byte kind, only valid with ENTRY_PREFIX set
   localparam int PREFIX_EXT_BIT = 0;
   localparam int PREFIX_REL_BIT = 1;
   localparam int PREFIX_ACK_BIT = 2;

   // arrow keys as amiga codes
   localparam amiga_code_t JOY_KEY_UP    = 7'h4c;
   localparam amiga_code_t JOY_KEY_DOWN  = 7'h4d;
   localparam amiga_code_t JOY_KEY_RIGHT = 7'h4e;
   localparam amiga_code_t JOY_KEY_LEFT  = 7'h4f;

   // joystick line positions
   localparam int JOY_RIGHT = 0;
   localparam int JOY_LEFT  = 1;
   localparam int JOY_DOWN  = 2;
   localparam int JOY_UP    = 3;
   localparam int JOY_FIRE0 = 4;
   localparam int JOY_FIRE1 = 5;

   // key queue
   localparam int KEY_QUEUE_DEPTH = 4;
   localparam int KEY_PTR_W       = $clog2(KEY_QUEUE_DEPTH);
   localparam int KEY_COUNT_W     = $clog2(KEY_QUEUE_DEPTH + 1);

   // bit 0 is the extended part, bit 1 the release part
   typedef enum logic [1:0] {
      PREFIX_NONE    = 2'b00,
      PREFIX_EXT     = 2'b01,
      PREFIX_REL     = 2'b10,
      PREFIX_EXT_REL = 2'b11
   } prefix_state_t;

endpackage

`default_nettype wire

// File: source/scan_code_table.sv
/* combinational scan code set 2 to amiga key table,
   indexed by the extended flag and the ps/2 byte */
`timescale 1ns/1ps
`default_nettype none

module scan_code_table import ps2_amiga_keymap_pkg::*; (
   input  wire table_index_t index,
   output table_entry_t      entry
);

   always_comb begin
      case (index)
         9'h001: entry = 16'h8058; // F9
         9'h003: entry = 16'h8054; // F5
         9'h004: entry = 16'h8052; // F3
         9'h005: entry = 16'h8050; // F1
         9'h006: entry = 16'h8051; // F2
         9'h009: entry = 16'h8059; // F10
         9'h00a: entry = 16'h8057; // F8
         9'h00b: entry = 16'h8055; // F6
         9'h00c: entry = 16'h8053; // F4
         9'h00d: entry = 16'h8042; // tab
         9'h00e: entry = 16'h8000; // backtick
         9'h011: entry = 16'ha064; // left alt
         9'h012: entry = 16'h8060; // left shift
         9'h014: entry = 16'hc063; // control
         9'h015: entry = 16'h8010;
         9'h016: entry = 16'h8001; // 1
         9'h01a: entry = 16'h8031;
         9'h01b: entry = 16'h8021;
         9'h01c: entry = 16'h8020; // a
         9'h01d: entry = 16'h8011;
         9'h01e: entry = 16'h8002;
         9'h021: entry = 16'h8033;
         9'h022: entry = 16'h8032;
         9'h023: entry = 16'h8022;
         9'h024: entry = 16'h8012;
         9'h025: entry = 16'h8004;
         9'h026: entry = 16'h8003;
         9'h029: entry = 16'h8040; // space
         9'h02a: entry = 16'h8034;
         9'h02b: entry = 16'h8023;
         9'h02c: entry = 16'h8014;
         9'h02d: entry = 16'h8013;
         9'h02e: entry = 16'h8005;
         9'h031: entry = 16'h8036;
         9'h032: entry = 16'h8035;
         9'h033: entry = 16'h8025;
         9'h034: entry = 16'h8024;
         9'h035: entry = 16'h8015;
         9'h036: entry = 16'h8006;
         9'h03a: entry = 16'h8037;
         9'h03b: entry = 16'h8026;
         9'h03c: entry = 16'h8016;
         9'h03d: entry = 16'h8007;
         9'h03e: entry = 16'h8008;
         9'h041: entry = 16'h8038; // comma
         9'h042: entry = 16'h8027;
         9'h043: entry = 16'h8017;
         9'h044: entry = 16'h8018;
         9'h045: entry = 16'h800a; // 0
         9'h046: entry = 16'h8009;
         9'h049: entry = 16'h8039; // period
         9'h04a: entry = 16'h803a; // slash
         9'h04b: entry = 16'h8028;
         9'h04c: entry = 16'h8029; // semicolon
         9'h04d: entry = 16'h8019;
         9'h04e: entry = 16'h800b; // minus
         9'h052: entry = 16'h802a; // quote
         9'h054: entry = 16'h801a; // open bracket
         9'h055: entry = 16'h800c; // equals
         9'h058: entry = 16'h8062; // caps lock, plain key now
         9'h059: entry = 16'h8061; // right shift
         9'h05a: entry = 16'h8044; // return
         9'h05b: entry = 16'h801b; // close bracket
         9'h05d: entry = 16'h802b; // iso key next to return
         9'h061: entry = 16'h8030; // iso key next to left shift
         9'h066: entry = 16'h8041; // backspace
         9'h069: entry = 16'h821d; // KP 1
         9'h06b: entry = 16'h822d; // KP 4
         9'h06c: entry = 16'h823d; // KP 7
         9'h070: entry = 16'h820f; // KP 0
         9'h071: entry = 16'h823c; // KP .
         9'h072: entry = 16'h821e; // KP 2
         9'h073: entry = 16'h822e; // KP 5
         9'h074: entry = 16'h822f; // KP 6
         9'h075: entry = 16'h823e; // KP 8
         9'h076: entry = 16'h8045; // escape
         9'h077: entry = 16'h0400; // num lock, no amiga key
         9'h079: entry = 16'h825e; // KP +
         9'h07a: entry = 16'h821f; // KP 3
         9'h07b: entry = 16'h824a; // KP -
         9'h07c: entry = 16'h825d; // KP *
         9'h07d: entry = 16'h823f; // KP 9
         9'h083: entry = 16'h8056; // F7
         // extended half
         9'h111: entry = 16'h8065; // right alt, plain key now
         9'h11f: entry = 16'h8066; // left gui as left amiga
         9'h127: entry = 16'h8067; // right gui as right amiga
         9'h12f: entry = 16'h8067; // apps as right amiga
         9'h14a: entry = 16'h825c; // KP /
         9'h15a: entry = 16'h8243; // KP enter
         9'h16b: entry = 16'h804f; // arrow left
         9'h170: entry = 16'h805f; // insert as help
         9'h171: entry = 16'h8046; // delete
         9'h172: entry = 16'h804d; // arrow down
         9'h174: entry = 16'h804e; // arrow right
         9'h175: entry = 16'h804c; // arrow up
         // protocol bytes, same in both halves
         9'h0e0, 9'h1e0: entry = 16'h0081; // extended prefix
         9'h0f0, 9'h1f0: entry = 16'h0082; // release prefix
         9'h0fa, 9'h1fa: entry = 16'h0084; // acknowledge
         default: entry = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: source/scan_decode.sv
/* input handshake, E0/F0 prefix tracking and the registered table
   entry that forms the pipeline stage */
`timescale 1ns/1ps
`default_nettype none

module scan_decode import ps2_amiga_keymap_pkg::*; (
   input  wire logic       clk,
   input  wire logic       reset,
   input  wire scan_byte_t scan_code,
   input  wire logic       scan_valid,
   output logic            scan_ready,
   output table_entry_t    entry,
   output logic            entry_upstroke,
   output logic            entry_valid,
   input  wire logic       entry_take
);

   prefix_state_t prefix_state;
   prefix_state_t prefix_next;
   table_entry_t  lookup;
   logic          ext_flag;
   logic          rel_flag;
   logic          accept;
   logic          is_ext;
   logic          is_rel;
   logic          is_ack;

   assign ext_flag = (prefix_state == PREFIX_EXT) || (prefix_state == PREFIX_EXT_REL);
   assign rel_flag = (prefix_state == PREFIX_REL) || (prefix_state == PREFIX_EXT_REL);

   scan_code_table u_scan_code_table (
      .index (table_index_t'({ext_flag, scan_code})),
      .entry (lookup)
   );

   assign scan_ready = !entry_valid || entry_take; // stage empty or draining
   assign accept     = scan_valid && scan_ready;

   assign is_ext = lookup[ENTRY_PREFIX] && lookup[PREFIX_EXT_BIT];
   assign is_rel = lookup[ENTRY_PREFIX] && lookup[PREFIX_REL_BIT];
   assign is_ack = lookup[ENTRY_PREFIX] && lookup[PREFIX_ACK_BIT];

   always_comb begin
      prefix_next = prefix_state;
      if (is_ext)
         prefix_next = rel_flag ? PREFIX_EXT_REL : PREFIX_EXT;
      else if (is_rel)
         prefix_next = ext_flag ? PREFIX_EXT_REL : PREFIX_REL;
      else if (!is_ack)
         prefix_next = PREFIX_NONE; // any real byte ends the sequence
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         prefix_state <= PREFIX_NONE;
         entry_valid  <= 1'b0;
      end else if (accept) begin
         prefix_state <= prefix_next;
         entry_valid  <= 1'b1;
      end else if (entry_take) begin
         entry_valid <= 1'b0;
      end
   end

   // payload, release flag taken before the state update
   always_ff @(posedge clk) begin
      if (accept) begin
         entry          <= lookup;
         entry_upstroke <= rel_flag;
      end
   end

endmodule

`default_nettype wire
